// File: design/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// pc and data width, rv64
`define XLEN 64

// one uncompressed instruction
`define INST_LEN 32

// address of the very first fetch
`define RESET_PC 64'h8000_0000

// 64-bit rows, 2 KiB of program space from the reset pc
`define IMEM_WORDS 256

// row index width
`define IMEM_IDX_W 8

`endif

// File: design/fetch_types_pkg.sv
`default_nettype none

`include "fetch_defs.svh"

package fetch_types_pkg;

    // pc, mtvec and mepc values
    typedef logic [`XLEN-1:0] xlen_t;

    // one fetched instruction
    typedef logic [`INST_LEN-1:0] inst_t;

    // one sram row, two instructions side by side
    typedef logic [`XLEN-1:0] imem_word_t;

    // sram row number
    typedef logic [`IMEM_IDX_W-1:0] imem_idx_t;

endpackage

`default_nettype wire

// File: design/trap_pkg.sv
`default_nettype none

package trap_pkg;

    // where the core is running
    // main program or trap handler
    typedef enum logic [0:0] {
        TRAP_RUN     = 1'b0,
        TRAP_HANDLER = 1'b1
    } trap_state_e;

    // target of the csr write port
    typedef enum logic [0:0] {
        CSR_MTVEC = 1'b0,
        CSR_MEPC  = 1'b1
    } csr_sel_e;

endpackage

`default_nettype wire

// File: design/imem_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module imem_sram
    import fetch_types_pkg::*;
(
    input  wire logic       clk,
    input  wire xlen_t      addr_i,
    input  wire logic       wr_en_i,
    input  wire imem_idx_t  wr_idx_i,
    input  wire imem_word_t wr_data_i,
    output imem_word_t      rdata_o,
    output logic            data_valid_o
);

    // byte offset inside a row takes the low 3 bits
    localparam int ROW_LSB = 3;
    localparam int ROW_MSB = ROW_LSB + `IMEM_IDX_W - 1;
    localparam xlen_t BASE = `RESET_PC;

    imem_word_t mem_q [`IMEM_WORDS];
    imem_idx_t  rd_idx;

    // row select straight from the fetch address
    assign rd_idx = addr_i[ROW_MSB:ROW_LSB];

    // inside the window when the upper bits match the base
    assign data_valid_o = (addr_i[`XLEN-1:ROW_MSB+1] == BASE[`XLEN-1:ROW_MSB+1]);

    // asynchronous read returns zero outside the window
    assign rdata_o = data_valid_o ? mem_q[rd_idx] : '0;

    // load port uses the row index as is
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem_q[wr_idx_i] <= wr_data_i;
        end
    end

endmodule

`default_nettype wire

// File: design/if_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module if_stage
    import fetch_types_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       is_jump_i,
    input  wire xlen_t      pc_jump_i,
    input  wire xlen_t      csr_mtvec_i,
    input  wire xlen_t      csr_mepc_i,
    input  wire logic       in_trap_i,
    input  wire logic       out_trap_i,
    input  wire logic       stall_n_i,
    input  wire imem_word_t sram_rdata_i,
    input  wire logic       sram_data_valid_i,
    output xlen_t           pc_next_o,
    output xlen_t           pc_o,
    output inst_t           instr_o,
    output logic            instr_valid_o,
    output xlen_t           sram_addr_o
);

    localparam xlen_t PC_STEP  = xlen_t'(4);
    // one step before reset pc so the first pc_next is the reset pc
    localparam xlen_t PC_RESET = xlen_t'(`RESET_PC) - PC_STEP;

    inst_t fetch_half;

    // next pc, jump first, then trap entry, trap return, sequential
    always_comb begin
        if (is_jump_i) begin
            pc_next_o = pc_jump_i;
        end else if (in_trap_i) begin
            pc_next_o = csr_mtvec_i;
        end else if (out_trap_i) begin
            pc_next_o = csr_mepc_i;
        end else begin
            pc_next_o = pc_o + PC_STEP;
        end
    end

    // sram sees the next pc directly
    assign sram_addr_o   = pc_next_o;
    assign instr_valid_o = sram_data_valid_i;

    // address bit 2 picks the upper instruction of the row
    assign fetch_half = sram_addr_o[2] ? sram_rdata_i[2*`INST_LEN-1:`INST_LEN]
                                       : sram_rdata_i[`INST_LEN-1:0];

    // fetch register, frozen while stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_o    <= PC_RESET;
            instr_o <= '0;
        end else if (stall_n_i) begin
            pc_o    <= pc_next_o;
            instr_o <= fetch_half;
        end
    end

    // no compressed support, every fetch is word aligned
    a_addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        sram_addr_o[1:0] == 2'b00)
        else $error("if_stage: misaligned fetch address %h", sram_addr_o);

    // trap controller never enters and leaves in one cycle
    a_trap_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        !(in_trap_i && out_trap_i))
        else $error("if_stage: trap entry and exit together");

endmodule

`default_nettype wire

// File: design/jal_predecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module jal_predecode
    import fetch_types_pkg::*;
(
    input  wire inst_t instr_i,
    input  wire xlen_t pc_i,
    input  wire logic  instr_valid_i,
    output logic       is_jump_o,
    output xlen_t      pc_jump_o
);

    localparam logic [6:0] OPC_JAL = 7'b110_1111;
    // j-type immediate is 21 bits with bit 0 always zero
    localparam int J_IMM_W = 21;

    logic [J_IMM_W-1:0] j_imm;
    xlen_t              j_imm_sext;

    // only a fetched instruction may redirect
    // keeps the zero word after reset from ever matching
    assign is_jump_o = instr_valid_i && (instr_i[6:0] == OPC_JAL);

    // imm[20|10:1|11|19:12] scattered over instr[31:12]
    assign j_imm = {instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    // sign extend to full pc width
    assign j_imm_sext = {{(`XLEN-J_IMM_W){j_imm[J_IMM_W-1]}}, j_imm};

    // target relative to the jal itself
    assign pc_jump_o = pc_i + j_imm_sext;

endmodule

`default_nettype wire

// File: design/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl
    import fetch_types_pkg::*;
    import trap_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     stall_n_i,
    input  wire logic     trap_req_i,
    input  wire logic     mret_i,
    input  wire xlen_t    pc_i,
    input  wire logic     csr_wr_en_i,
    input  wire csr_sel_e csr_wr_sel_i,
    input  wire xlen_t    csr_wr_data_i,
    output xlen_t         mtvec_o,
    output xlen_t         mepc_o,
    output logic          in_trap_o,
    output logic          out_trap_o,
    output logic          in_handler_o
);

    trap_state_e state_q;
    trap_state_e state_d;

    // entry only from the main program, exit only from the handler
    // nothing accepted while stalled
    assign in_trap_o    = trap_req_i && stall_n_i && (state_q == TRAP_RUN);
    assign out_trap_o   = mret_i && stall_n_i && (state_q == TRAP_HANDLER);
    assign in_handler_o = (state_q == TRAP_HANDLER);

    always_comb begin
        state_d = state_q;
        case (state_q)
            TRAP_RUN: begin
                if (in_trap_o) begin
                    state_d = TRAP_HANDLER;
                end
            end
            TRAP_HANDLER: begin
                if (out_trap_o) begin
                    state_d = TRAP_RUN;
                end
            end
            default: state_d = TRAP_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= TRAP_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // handler base, software written only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_o <= '0;
        end else if (csr_wr_en_i && (csr_wr_sel_i == CSR_MTVEC)) begin
            mtvec_o <= csr_wr_data_i;
        end
    end

    // return address, trap capture beats a csr write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_o <= '0;
        end else if (in_trap_o) begin
            mepc_o <= pc_i;
        end else if (csr_wr_en_i && (csr_wr_sel_i == CSR_MEPC)) begin
            mepc_o <= csr_wr_data_i;
        end
    end

    // no second entry until the handler has returned
    a_no_nested_trap: assert property (@(posedge clk) disable iff (!rst_n)
        in_trap_o |=> (!in_trap_o until_with out_trap_o))
        else $error("trap_ctrl: trap entry while in handler");

    // handler entry must land on a word boundary
    a_mtvec_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        in_trap_o |-> (mtvec_o[1:0] == 2'b00))
        else $error("trap_ctrl: misaligned mtvec %h", mtvec_o);

endmodule

`default_nettype wire

// File: design/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top
    import fetch_types_pkg::*;
    import trap_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       stall_n_i,
    input  wire logic       trap_req_i,
    input  wire logic       mret_i,
    input  wire logic       csr_wr_en_i,
    input  wire csr_sel_e   csr_wr_sel_i,
    input  wire xlen_t      csr_wr_data_i,
    input  wire logic       imem_wr_en_i,
    input  wire imem_idx_t  imem_wr_idx_i,
    input  wire imem_word_t imem_wr_data_i,
    output xlen_t           pc_o,
    output inst_t           instr_o,
    output logic            instr_valid_o,
    output logic            in_handler_o
);

    xlen_t      sram_addr;
    imem_word_t sram_rdata;
    logic       sram_data_valid;
    logic       is_jump;
    xlen_t      pc_jump;
    xlen_t      mtvec;
    xlen_t      mepc;
    logic       in_trap;
    logic       out_trap;
    // valid of the instruction sitting in the fetch register
    logic       instr_valid_q;

    imem_sram u_sram (
        .clk          (clk),
        .addr_i       (sram_addr),
        .wr_en_i      (imem_wr_en_i),
        .wr_idx_i     (imem_wr_idx_i),
        .wr_data_i    (imem_wr_data_i),
        .rdata_o      (sram_rdata),
        .data_valid_o (sram_data_valid)
    );

    if_stage u_if (
        .clk               (clk),
        .rst_n             (rst_n),
        .is_jump_i         (is_jump),
        .pc_jump_i         (pc_jump),
        .csr_mtvec_i       (mtvec),
        .csr_mepc_i        (mepc),
        .in_trap_i         (in_trap),
        .out_trap_i        (out_trap),
        .stall_n_i         (stall_n_i),
        .sram_rdata_i      (sram_rdata),
        .sram_data_valid_i (sram_data_valid),
        .pc_next_o         (),
        .pc_o              (pc_o),
        .instr_o           (instr_o),
        .instr_valid_o     (instr_valid_o),
        .sram_addr_o       (sram_addr)
    );

    // tracks instr_o with the same enable as the fetch register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_valid_q <= 1'b0;
        end else if (stall_n_i) begin
            instr_valid_q <= instr_valid_o;
        end
    end

    jal_predecode u_jal (
        .instr_i       (instr_o),
        .pc_i          (pc_o),
        .instr_valid_i (instr_valid_q),
        .is_jump_o     (is_jump),
        .pc_jump_o     (pc_jump)
    );

    trap_ctrl u_trap (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_n_i     (stall_n_i),
        .trap_req_i    (trap_req_i),
        .mret_i        (mret_i),
        .pc_i          (pc_o),
        .csr_wr_en_i   (csr_wr_en_i),
        .csr_wr_sel_i  (csr_wr_sel_i),
        .csr_wr_data_i (csr_wr_data_i),
        .mtvec_o       (mtvec),
        .mepc_o        (mepc),
        .in_trap_o     (in_trap),
        .out_trap_o    (out_trap),
        .in_handler_o  (in_handler_o)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // reset held for 16 rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/fetch_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_checker
    import fetch_types_pkg::*;
    import trap_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst_n,
    input wire logic       stall_n_i,
    input wire logic       trap_req_i,
    input wire logic       mret_i,
    input wire logic       csr_wr_en_i,
    input wire csr_sel_e   csr_wr_sel_i,
    input wire xlen_t      csr_wr_data_i,
    input wire logic       imem_wr_en_i,
    input wire imem_idx_t  imem_wr_idx_i,
    input wire imem_word_t imem_wr_data_i,
    input wire xlen_t      pc_i,
    input wire inst_t      instr_i,
    input wire logic       instr_valid_i,
    input wire logic       in_handler_i
);

    localparam xlen_t BASE = `RESET_PC;
    localparam xlen_t SPAN = xlen_t'(`IMEM_WORDS * 8);

    // own copy of the program built from the load port
    imem_word_t mem [`IMEM_WORDS];

    // model of the fetch register and the trap controller
    xlen_t m_pc;
    inst_t m_instr;
    logic  m_vq;
    logic  m_hand;
    xlen_t m_mtvec;
    xlen_t m_mepc;

    string cur_name  = "none";
    int    test_errs = 0;
    int    n_pass    = 0;
    int    n_fail    = 0;

    function automatic logic in_window(xlen_t a);
        return (a >= BASE) && (a < BASE + SPAN);
    endfunction

    // j-type offset summed field by field
    // instr bit 31 counts as -2^20
    function automatic xlen_t jal_target(xlen_t pc, inst_t ins);
        longint off;
        off = longint'(ins[30:21]) * 2
            + longint'(ins[20]) * 2048
            + longint'(ins[19:12]) * 4096
            - longint'(ins[31]) * 1048576;
        return pc + xlen_t'(off);
    endfunction

    task automatic start_test(string name);
        cur_name  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            n_pass++;
            $display("test %s passed", cur_name);
        end else begin
            n_fail++;
            $display("test %s failed with %0d mismatches", cur_name, test_errs);
        end
    endtask

    task automatic compare(string what, xlen_t exp, xlen_t act);
        if (exp !== act) begin
            test_errs++;
            $display("[FAIL] %s %s expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    always @(posedge clk or negedge rst_n) begin : model
        xlen_t      nxt;
        logic       jmp;
        logic       tin;
        logic       tout;
        logic       vld;
        imem_word_t row;
        inst_t      half;
        if (!rst_n) begin
            m_pc    = BASE - 4;
            m_instr = '0;
            m_vq    = 1'b0;
            m_hand  = 1'b0;
            m_mtvec = '0;
            m_mepc  = '0;
        end else begin
            compare("pc_o", m_pc, pc_i);
            compare("instr_o", xlen_t'(m_instr), xlen_t'(instr_i));
            compare("in_handler_o", xlen_t'(m_hand), xlen_t'(in_handler_i));
            // jump beats trap entry beats trap return
            jmp  = m_vq && (m_instr[6:0] == 7'b1101111);
            tin  = trap_req_i && stall_n_i && !m_hand;
            tout = mret_i && stall_n_i && m_hand;
            if (jmp)
                nxt = jal_target(m_pc, m_instr);
            else if (tin)
                nxt = m_mtvec;
            else if (tout)
                nxt = m_mepc;
            else
                nxt = m_pc + 4;
            vld  = in_window(nxt);
            row  = vld ? mem[nxt[10:3]] : '0;
            half = nxt[2] ? row[63:32] : row[31:0];
            compare("instr_valid_o", xlen_t'(vld), xlen_t'(instr_valid_i));
            // csrs use the pc from before this edge
            if (csr_wr_en_i && csr_wr_sel_i == CSR_MTVEC)
                m_mtvec = csr_wr_data_i;
            if (tin)
                m_mepc = m_pc;
            else if (csr_wr_en_i && csr_wr_sel_i == CSR_MEPC)
                m_mepc = csr_wr_data_i;
            if (tin)
                m_hand = 1'b1;
            else if (tout)
                m_hand = 1'b0;
            if (stall_n_i) begin
                m_pc    = nxt;
                m_instr = half;
                m_vq    = vld;
            end
        end
        // write lands after the async read of this cycle
        if (clk && imem_wr_en_i)
            mem[imem_wr_idx_i] = imem_wr_data_i;
    end

endmodule

`default_nettype wire

// File: sim/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defs.svh"

module fetch_tb
    import fetch_types_pkg::*;
    import trap_pkg::*;
();

    localparam logic [31:0] SEED = 32'h13c8e709;
    localparam inst_t       NOP  = 32'h0000_0013;

    typedef struct {
        string    name;
        logic     stall_n;
        logic     trap;
        logic     mret;
        logic     csr_en;
        csr_sel_e csr_sel;
        xlen_t    csr_data;
        int       cycles;
        logic     until_invalid;
    } row_t;

    logic       clk;
    logic       rst_n;
    logic       stall_n;
    logic       trap_req;
    logic       mret;
    logic       csr_wr_en;
    csr_sel_e   csr_wr_sel;
    xlen_t      csr_wr_data;
    logic       imem_wr_en;
    imem_idx_t  imem_wr_idx;
    imem_word_t imem_wr_data;
    xlen_t      pc;
    inst_t      instr;
    logic       instr_valid;
    logic       in_handler;

    row_t       table_q [$];
    imem_word_t prog [12];
    logic       timed_out;

    tb_clock_gen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fetch_top dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall_n_i      (stall_n),
        .trap_req_i     (trap_req),
        .mret_i         (mret),
        .csr_wr_en_i    (csr_wr_en),
        .csr_wr_sel_i   (csr_wr_sel),
        .csr_wr_data_i  (csr_wr_data),
        .imem_wr_en_i   (imem_wr_en),
        .imem_wr_idx_i  (imem_wr_idx),
        .imem_wr_data_i (imem_wr_data),
        .pc_o           (pc),
        .instr_o        (instr),
        .instr_valid_o  (instr_valid),
        .in_handler_o   (in_handler)
    );

    fetch_checker u_chk (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall_n_i      (stall_n),
        .trap_req_i     (trap_req),
        .mret_i         (mret),
        .csr_wr_en_i    (csr_wr_en),
        .csr_wr_sel_i   (csr_wr_sel),
        .csr_wr_data_i  (csr_wr_data),
        .imem_wr_en_i   (imem_wr_en),
        .imem_wr_idx_i  (imem_wr_idx),
        .imem_wr_data_i (imem_wr_data),
        .pc_i           (pc),
        .instr_i        (instr),
        .instr_valid_i  (instr_valid),
        .in_handler_i   (in_handler)
    );

    // jal x0, off
    function automatic inst_t encode_jal(int off);
        logic [20:0] imm;
        imm = off[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'b1101111};
    endfunction

    // random filler, never a jal
    function automatic inst_t random_inst();
        inst_t w;
        w = $urandom;
        if (w[6:0] == 7'b1101111)
            w[0] = 1'b0;
        return w;
    endfunction

    task automatic add_row(string name, logic stn, logic trp, logic mrt, logic cen,
                           csr_sel_e csel, xlen_t cdata, int cyc, logic until_inv);
        row_t r;
        r = '{name, stn, trp, mrt, cen, csel, cdata, cyc, until_inv};
        table_q.push_back(r);
    endtask

    initial begin
        stall_n      = 1'b0;
        trap_req     = 1'b0;
        mret         = 1'b0;
        csr_wr_en    = 1'b0;
        csr_wr_sel   = CSR_MTVEC;
        csr_wr_data  = '0;
        imem_wr_en   = 1'b0;
        imem_wr_idx  = '0;
        imem_wr_data = '0;
        timed_out    = 1'b0;
        void'($urandom(SEED));

        // 0x10 jumps to 0x40, 0x44 back to 0x18, 0x3c on to 0x5c
        foreach (prog[i])
            prog[i] = {NOP, NOP};
        prog[0] = {32'h0010_0093, NOP};
        prog[1] = {32'h0030_0193, 32'h0020_0113};
        prog[2] = {32'h0040_0213, encode_jal(32'h30)};
        prog[7] = {encode_jal(32'h20), NOP};
        prog[8] = {encode_jal(-32'sh2c), NOP};

        add_row("seq_start",   1, 0, 0, 0, CSR_MTVEC, '0, 4, 0);
        add_row("jal_forward", 1, 0, 0, 0, CSR_MTVEC, '0, 3, 0);
        add_row("jal_back",    1, 0, 0, 0, CSR_MTVEC, '0, 4, 0);
        add_row("stall_hold",  0, 1, 0, 0, CSR_MTVEC, '0, 5, 0);
        add_row("resume",      1, 0, 0, 0, CSR_MTVEC, '0, 8, 0);
        add_row("mtvec_write", 1, 0, 0, 1, CSR_MTVEC, 64'h8000_0400, 2, 0);
        add_row("trap_enter",  1, 1, 0, 0, CSR_MTVEC, '0, 4, 0);
        add_row("trap_nested", 1, 1, 0, 0, CSR_MTVEC, '0, 3, 0);
        add_row("mret_return", 1, 0, 1, 0, CSR_MTVEC, '0, 4, 0);
        add_row("run_off_end", 1, 0, 0, 0, CSR_MTVEC, '0, 1, 1);

        begin : run
            int w;
            u_chk.start_test("load");
            // program rows land during reset, the rest under stall
            for (int i = 0; i < `IMEM_WORDS; i++) begin
                @(posedge clk);
                imem_wr_en   <= 1'b1;
                imem_wr_idx  <= imem_idx_t'(i);
                imem_wr_data <= (i < 12) ? prog[i] : {random_inst(), random_inst()};
            end
            @(posedge clk);
            imem_wr_en <= 1'b0;
            for (w = 0; w < 100 && !rst_n; w++)
                @(posedge clk);
            if (!rst_n) begin
                timed_out = 1'b1;
                $display("timeout: reset was never released");
                disable run;
            end
            @(negedge clk);
            u_chk.end_test();

            foreach (table_q[t]) begin
                u_chk.start_test(table_q[t].name);
                @(posedge clk);
                stall_n     <= table_q[t].stall_n;
                trap_req    <= table_q[t].trap;
                mret        <= table_q[t].mret;
                csr_wr_en   <= table_q[t].csr_en;
                csr_wr_sel  <= table_q[t].csr_sel;
                csr_wr_data <= table_q[t].csr_data;
                // strobes last one cycle only
                for (int c = 1; c < table_q[t].cycles; c++) begin
                    @(posedge clk);
                    trap_req  <= 1'b0;
                    mret      <= 1'b0;
                    csr_wr_en <= 1'b0;
                end
                if (table_q[t].until_invalid) begin
                    for (w = 0; w < 2000; w++) begin
                        @(posedge clk);
                        trap_req  <= 1'b0;
                        mret      <= 1'b0;
                        csr_wr_en <= 1'b0;
                        if (!instr_valid)
                            break;
                    end
                    if (w == 2000) begin
                        timed_out = 1'b1;
                        $display("timeout: instr_valid_o never dropped past the window");
                        disable run;
                    end
                end
                @(negedge clk);
                u_chk.end_test();
            end
        end

        $display("tests passed %0d, failed %0d", u_chk.n_pass, u_chk.n_fail);
        if (timed_out || u_chk.n_fail != 0) begin
            $display("FAIL: see errors above");
        end else begin
            $display("PASS: all tests");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/fetch_types_pkg.sv
design/trap_pkg.sv
design/imem_sram.sv
design/if_stage.sv
design/jal_predecode.sv
design/trap_ctrl.sv
design/fetch_top.sv
sim/tb_clock_gen.sv
sim/fetch_checker.sv
sim/fetch_tb.sv

// File: Bender.yml
package:
  name: fetch_front

sources:
  - include_dirs:
      - design
    files:
      - design/fetch_types_pkg.sv
      - design/trap_pkg.sv
      - design/imem_sram.sv
      - design/if_stage.sv
      - design/jal_predecode.sv
      - design/trap_ctrl.sv
      - design/fetch_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_clock_gen.sv
      - sim/fetch_checker.sv
      - sim/fetch_tb.sv
